// ==== include/aes_settings.svh ====
// AES core settings
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// Cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// Incrementing field in the low bits of the CTR block
`define AES_CTR_WIDTH 32

// Accepting edge to out_valid, in cycles
`define AES_LATENCY 56

// Watchdog margin per block
`define AES_TB_TIMEOUT_SCALE 4

`endif

// ==== hdl/aes_pkg.sv ====
// AES core types
package aes_pkg;

	// One 128-bit block, flat or by column
	// Column 0 is the most significant word
	typedef union packed {
		logic [127:0]       flat;
		logic [0:3][31:0]   col;
	} aes_block_u;

	// Chaining mode, code 2'b11 reserved and run as ECB
	typedef enum logic [1:0] {
		AES_MODE_ECB = 2'b00,
		AES_MODE_CBC = 2'b01,
		AES_MODE_CTR = 2'b10
	} aes_mode_e;

	typedef struct packed {
		aes_mode_e  mode;
		logic       new_chain;
		aes_block_u key;
		aes_block_u iv;
		aes_block_u data;
	} aes_req_t;

	typedef struct packed {
		aes_block_u data;
	} aes_rsp_t;

	// Shared S-box source
	typedef enum logic [2:0] {
		SBOX_COL0   = 3'd0,
		SBOX_COL1   = 3'd1,
		SBOX_COL2   = 3'd2,
		SBOX_COL3   = 3'd3,
		SBOX_G_FUNC = 3'd4
	} aes_sbox_sel_e;

	// Column register load source
	typedef enum logic [1:0] {
		COL_SHIFT_ROWS = 2'b00,
		COL_ADD_RK     = 2'b01,
		COL_INPUT      = 2'b10
	} aes_col_sel_e;

endpackage

// ==== hdl/aes_sbox.sv ====
// Four-lane forward S-box
`timescale 1ns/1ps

module aes_sbox
(
	input  logic [31:0] in_word,
	output logic [31:0] out_word
);

	//==========================================================================
	// Forward substitution table, entry 0 in the top byte
	//==========================================================================
	localparam logic [0:255][7:0] SBOX = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	//==========================================================================
	// Byte lanes
	//==========================================================================
	// Lane 0 is the top byte of the word
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			out_word[31 - 8*i -: 8] = SBOX[in_word[31 - 8*i -: 8]];
		end
	end

endmodule

// ==== hdl/aes_key_schedule.sv ====
// AES-128 key expansion
`timescale 1ns/1ps

module aes_key_schedule
(
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::aes_block_u key_in,
	input  logic               key_init,
	input  logic [3:0]         key_en,
	input  logic [31:0]        sub_word,
	output aes_pkg::aes_block_u rk,
	output logic [31:0]        g_word
);
	import aes_pkg::*;

	// Current round key words
	aes_block_u  key_q;
	logic [7:0]  rcon_q;
	logic [31:0] w0_next;

	//==========================================================================
	// Word expansion
	//==========================================================================
	// g-function result arrives on sub_word during the key cycle
	assign w0_next = key_q.col[0] ^ sub_word ^ {rcon_q, 24'h000000};

	// RotWord of word 3, goes to the shared S-box
	assign g_word = {key_q.col[3][23:0], key_q.col[3][31:24]};

	// Word c chains off the already updated word c-1
	// Column c sees its new word in the same cycle
	always_comb
	begin
		rk.col[0] = key_q.col[0];
		for (int c = 1; c < 4; c++)
		begin
			if (key_en[c])
				rk.col[c] = key_q.col[c] ^ key_q.col[c-1];
			else
				rk.col[c] = key_q.col[c];
		end
	end

	// Key words
	always_ff @(posedge clk)
	begin
		if (key_init)
			key_q <= key_in;
		else
		begin
			if (key_en[0])
				key_q.col[0] <= w0_next;
			for (int c = 1; c < 4; c++)
			begin
				if (key_en[c])
					key_q.col[c] <= rk.col[c];
			end
		end
	end

	// Round constant, doubled in GF(2^8) after each key cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcon_q <= 8'h01;
		else if (key_init)
			rcon_q <= 8'h01;
		else if (key_en[0])
			rcon_q <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00);
	end

endmodule

// ==== hdl/aes_round_datapath.sv ====
// Column-serial round datapath
`timescale 1ns/1ps

module aes_round_datapath
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  aes_pkg::aes_block_u   cipher_in,
	input  aes_pkg::aes_block_u   rk,
	input  logic [31:0]           g_word,
	input  aes_pkg::aes_sbox_sel_e sbox_sel,
	input  aes_pkg::aes_col_sel_e  col_sel,
	input  logic [3:0]            col_en,
	input  logic                  last_round,
	output logic [31:0]           sub_word,
	output aes_pkg::aes_block_u   cipher_out
);
	import aes_pkg::*;

	aes_block_u  state_q;
	aes_block_u  pre_shift;
	aes_block_u  shifted;
	logic        first_q;
	logic [1:0]  col_idx;
	logic [31:0] col_cur;
	logic [31:0] mix_out;
	logic [31:0] ark;
	logic [31:0] sbox_in;
	logic [31:0] col_res;

	//==========================================================================
	// Round functions
	//==========================================================================
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [31:0] mix_column(input logic [31:0] w);
		logic [7:0] a0, a1, a2, a3;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// Row r rotates left by r columns
	function automatic aes_block_u shift_rows(input aes_block_u blk);
		aes_block_u res;
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
				res.col[c][31 - 8*r -: 8] = blk.col[(c + r) % 4][31 - 8*r -: 8];
		end
		return res;
	endfunction

	//==========================================================================
	// Column path
	//==========================================================================
	// Column in work follows the S-box select
	assign col_idx = sbox_sel[1:0];
	assign col_cur = state_q.col[col_idx];

	// No MixColumns in round 0 or the final round
	assign mix_out = (first_q || last_round) ? col_cur : mix_column(col_cur);
	assign ark     = mix_out ^ rk.col[col_idx];

	// Shared S-box, key g-function takes it in the key cycle
	assign sbox_in = (sbox_sel == SBOX_G_FUNC) ? g_word : ark;

	aes_sbox i_sbox
	(
		.in_word  (sbox_in),
		.out_word (sub_word)
	);

	// Final round stores the AddRoundKey result directly
	assign col_res = last_round ? ark : sub_word;

	// ShiftRows sees the column finished in this cycle
	always_comb
	begin
		pre_shift = state_q;
		pre_shift.col[col_idx] = col_res;
	end

	assign shifted = shift_rows(pre_shift);

	//==========================================================================
	// State registers
	//==========================================================================
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (col_en[i])
			begin
				case (col_sel)
					COL_INPUT:      state_q.col[i] <= cipher_in.col[i];
					COL_SHIFT_ROWS: state_q.col[i] <= shifted.col[i];
					default:        state_q.col[i] <= col_res;
				endcase
			end
		end
	end

	// Round 0 marker, set on block load, cleared by the first ShiftRows
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			first_q <= 1'b0;
		else if (col_en != 4'b0000)
		begin
			if (col_sel == COL_INPUT)
				first_q <= 1'b1;
			else if (col_sel == COL_SHIFT_ROWS)
				first_q <= 1'b0;
		end
	end

	assign cipher_out = state_q;

endmodule

// ==== hdl/aes_control_unit.sv ====
// AES round sequencer
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_control_unit
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	output aes_pkg::aes_sbox_sel_e sbox_sel,
	output aes_pkg::aes_col_sel_e  col_sel,
	output logic [3:0]             col_en,
	output logic [3:0]             key_en,
	output logic                   key_init,
	output logic                   last_round,
	output logic                   end_comp
);
	import aes_pkg::*;

	typedef enum logic [3:0] {
		ST_IDLE    = 4'd0,
		ST_R0_COL0 = 4'd1,
		ST_R0_COL1 = 4'd2,
		ST_R0_COL2 = 4'd3,
		ST_R0_COL3 = 4'd4,
		ST_KEY     = 4'd5,
		ST_COL0    = 4'd6,
		ST_COL1    = 4'd7,
		ST_COL2    = 4'd8,
		ST_COL3    = 4'd9,
		ST_READY   = 4'd10
	} state_e;

	state_e     state, next_state;
	logic [3:0] rd_count;

	//==========================================================================
	// State and round counter
	//==========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// Counts rounds 1 to 10, bumped in each key cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= 4'd0;
		else if (state == ST_IDLE)
			rd_count <= 4'd0;
		else if (state == ST_KEY)
			rd_count <= rd_count + 4'd1;
	end

	assign last_round = (rd_count == 4'(`AES_ROUNDS));

	// 4 cycles of round 0, then 5 per round
	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:    if (start) next_state = ST_R0_COL0;
			ST_R0_COL0: next_state = ST_R0_COL1;
			ST_R0_COL1: next_state = ST_R0_COL2;
			ST_R0_COL2: next_state = ST_R0_COL3;
			ST_R0_COL3: next_state = ST_KEY;
			ST_KEY:     next_state = ST_COL0;
			ST_COL0:    next_state = ST_COL1;
			ST_COL1:    next_state = ST_COL2;
			ST_COL2:    next_state = ST_COL3;
			ST_COL3:    next_state = last_round ? ST_READY : ST_KEY;
			default:    next_state = ST_IDLE;
		endcase
	end

	//==========================================================================
	// Output decode
	//==========================================================================
	always_comb
	begin
		sbox_sel = SBOX_COL0;
		col_sel  = COL_ADD_RK;
		col_en   = 4'b0000;
		key_en   = 4'b0000;
		key_init = 1'b0;
		end_comp = 1'b0;
		case (state)
			ST_IDLE:
			begin
				// Block and key load together
				if (start)
				begin
					col_sel  = COL_INPUT;
					col_en   = 4'b1111;
					key_init = 1'b1;
				end
			end
			ST_R0_COL0:
				col_en = 4'b0001;
			ST_R0_COL1:
			begin
				sbox_sel = SBOX_COL1;
				col_en   = 4'b0010;
			end
			ST_R0_COL2:
			begin
				sbox_sel = SBOX_COL2;
				col_en   = 4'b0100;
			end
			ST_R0_COL3:
			begin
				sbox_sel = SBOX_COL3;
				col_sel  = COL_SHIFT_ROWS;
				col_en   = 4'b1111;
			end
			ST_KEY:
			begin
				sbox_sel = SBOX_G_FUNC;
				key_en   = 4'b0001;
			end
			ST_COL0:
				col_en = 4'b0001;
			ST_COL1:
			begin
				sbox_sel = SBOX_COL1;
				col_en   = 4'b0010;
				key_en   = 4'b0010;
			end
			ST_COL2:
			begin
				sbox_sel = SBOX_COL2;
				col_en   = 4'b0100;
				key_en   = 4'b0100;
			end
			ST_COL3:
			begin
				sbox_sel = SBOX_COL3;
				key_en   = 4'b1000;
				// Final round skips ShiftRows reload
				if (last_round)
					col_en = 4'b1000;
				else
				begin
					col_sel = COL_SHIFT_ROWS;
					col_en  = 4'b1111;
				end
			end
			ST_READY:
				end_comp = 1'b1;
			default:
				end_comp = 1'b0;
		endcase
	end

endmodule

// ==== hdl/aes_chain_unit.sv ====
// Block chaining front end
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_chain_unit
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	output logic                in_ready,
	input  aes_pkg::aes_req_t   req,
	output logic                out_valid,
	input  logic                out_ready,
	output aes_pkg::aes_rsp_t   rsp,
	output logic                start,
	input  logic                end_comp,
	output aes_pkg::aes_block_u cipher_in,
	output aes_pkg::aes_block_u key_in,
	input  aes_pkg::aes_block_u cipher_out
);
	import aes_pkg::*;

	aes_req_t   req_q;
	aes_block_u chain_q;
	aes_block_u blk_result;
	logic       busy_q;
	logic       accept;
	logic       is_cbc;
	logic       is_ctr;
	logic [`AES_CTR_WIDTH-1:0] ctr_next;

	//==========================================================================
	// Handshake
	//==========================================================================
	// Free only with nothing in flight and no result waiting
	assign in_ready = !busy_q && !out_valid;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy_q    <= 1'b0;
			start     <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			start <= accept;
			if (accept)
				busy_q <= 1'b1;
			else if (end_comp)
				busy_q <= 1'b0;
			if (end_comp)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	//==========================================================================
	// Mode handling
	//==========================================================================
	// Reserved code falls through to ECB
	assign is_cbc = (req_q.mode == AES_MODE_CBC);
	assign is_ctr = (req_q.mode == AES_MODE_CTR);

	assign key_in   = req_q.key;
	assign ctr_next = chain_q.flat[`AES_CTR_WIDTH-1:0] + 1'b1;

	always_comb
	begin
		cipher_in  = req_q.data;
		blk_result = cipher_out;
		if (is_cbc)
			cipher_in.flat = req_q.data.flat ^ chain_q.flat;
		else if (is_ctr)
		begin
			cipher_in  = chain_q;
			// Keystream whitening
			blk_result.flat = req_q.data.flat ^ cipher_out.flat;
		end
	end

	// Request and result hold
	always_ff @(posedge clk)
	begin
		if (accept)
			req_q <= req;
		if (end_comp)
			rsp.data <= blk_result;
	end

	// Chain value, or CTR counter block
	always_ff @(posedge clk)
	begin
		if (accept && req.new_chain)
			chain_q <= req.iv;
		else if (end_comp)
		begin
			if (is_cbc)
				chain_q <= cipher_out;
			else if (is_ctr)
				chain_q.flat[`AES_CTR_WIDTH-1:0] <= ctr_next;
		end
	end

endmodule

// ==== hdl/aes_core_top.sv ====
// AES-128 core top level
`timescale 1ns/1ps

module aes_core_top
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  aes_pkg::aes_req_t req,
	output logic              out_valid,
	input  logic              out_ready,
	output aes_pkg::aes_rsp_t rsp
);
	import aes_pkg::*;

	// Chain unit to cipher
	logic          start;
	logic          end_comp;
	aes_block_u    cipher_in;
	aes_block_u    cipher_out;
	aes_block_u    key_in;

	// Sequencer enables
	aes_sbox_sel_e sbox_sel;
	aes_col_sel_e  col_sel;
	logic [3:0]    col_en;
	logic [3:0]    key_en;
	logic          key_init;
	logic          last_round;

	// Key schedule and shared S-box
	aes_block_u    rk;
	logic [31:0]   g_word;
	logic [31:0]   sub_word;

	aes_chain_unit i_chain
	(
		.clk, .rst_n,
		.in_valid, .in_ready, .req,
		.out_valid, .out_ready, .rsp,
		.start, .end_comp,
		.cipher_in, .key_in, .cipher_out
	);

	aes_control_unit i_ctrl
	(
		.clk, .rst_n, .start,
		.sbox_sel, .col_sel, .col_en,
		.key_en, .key_init, .last_round, .end_comp
	);

	aes_round_datapath i_datapath
	(
		.clk, .rst_n, .cipher_in, .rk, .g_word,
		.sbox_sel, .col_sel, .col_en, .last_round,
		.sub_word, .cipher_out
	);

	aes_key_schedule i_key
	(
		.clk, .rst_n, .key_in, .key_init, .key_en,
		.sub_word, .rk, .g_word
	);

endmodule

// ==== dv/aes_assert.sv ====
// Core protocol assertions
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_assert
(
	input logic              clk,
	input logic              rst_n,
	input logic              in_valid,
	input logic              in_ready,
	input aes_pkg::aes_req_t req,
	input logic              out_valid,
	input logic              out_ready,
	input aes_pkg::aes_rsp_t rsp,
	input logic              start,
	input logic              end_comp,
	input logic [3:0]        col_en,
	input logic [3:0]        key_en,
	input logic              key_init
);

	// Failed assertions so far
	int unsigned fail_count = 0;

	//==========================================================================
	// Handshake stability
	//==========================================================================
	// Source holds its request until the transfer
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(req))
	else
	begin
		$error("Request dropped or changed before in_ready");
		fail_count++;
	end

	// Result frozen under back-pressure
	a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(rsp))
	else
	begin
		$error("Result dropped or changed while out_ready low");
		fail_count++;
	end

	// Block in flight keeps the input side closed
	a_in_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && in_ready |=> !in_ready [* `AES_LATENCY])
	else
	begin
		$error("in_ready high with a block in flight");
		fail_count++;
	end

	//==========================================================================
	// Reset values and latency
	//==========================================================================
	a_reset_vals: assert property (@(posedge clk)
		!rst_n && $past(!rst_n) |-> !out_valid && in_ready && !start && !end_comp
			&& col_en == 4'b0000 && key_en == 4'b0000 && !key_init)
	else
	begin
		$error("Outputs or enables not at reset values");
		fail_count++;
	end

	// Accepting edge to out_valid
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && in_ready |-> ##(`AES_LATENCY + 1) out_valid)
	else
	begin
		$error("out_valid missing after the fixed latency");
		fail_count++;
	end

	// No early result
	a_no_early: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> $past(in_valid && in_ready, `AES_LATENCY + 1))
	else
	begin
		$error("out_valid rose without a request at the fixed latency");
		fail_count++;
	end

endmodule

bind aes_core_top aes_assert i_assert
(
	.clk, .rst_n,
	.in_valid, .in_ready, .req,
	.out_valid, .out_ready, .rsp,
	.start, .end_comp,
	.col_en, .key_en, .key_init
);

// ==== dv/aes_tb.sv ====
// AES core directed testbench
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_tb;
	import aes_pkg::*;

	// Blocks sent over all tests, the aborted one included
	localparam int NUM_BLOCKS     = 10;
	localparam int TIMEOUT_CYCLES = `AES_TB_TIMEOUT_SCALE * `AES_LATENCY * NUM_BLOCKS;

	// Published vectors, C.1 and appendix B
	localparam logic [127:0] KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] PT_A  = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [127:0] KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [127:0] PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
	localparam logic [127:0] CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	logic        out_valid;
	logic        out_ready;
	aes_req_t    req;
	aes_rsp_t    rsp;
	logic [31:0] lfsr_state;

	aes_core_top i_dut
	(
		.clk, .rst_n,
		.in_valid, .in_ready, .req,
		.out_valid, .out_ready, .rsp
	);

	//==========================================================================
	// Clock and watchdog
	//==========================================================================
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding",
			TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog timeout");
	end

	// Watch the bound checker
	initial
	begin
		wait (i_dut.i_assert.fail_count != 0);
		$display("A bound assertion failed during the run");
		$display("STATUS: FAIL");
		$fatal(1, "Assertion failure");
	end

	//==========================================================================
	// Helpers
	//==========================================================================
	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h00000000);
	endfunction

	// One step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return val;
	endfunction

	task automatic check_value(input string test_name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Check failed in %s", test_name);
		end
	endtask

	// Low for 10 rising edges, released on a falling edge
	task automatic apply_reset();
		@(negedge clk);
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	// Held until in_ready, transfer on the next rising edge
	task automatic send_request(input aes_mode_e mode, input logic new_chain,
		input logic [127:0] key, input logic [127:0] iv, input logic [127:0] data);
		@(negedge clk);
		req.mode      = mode;
		req.new_chain = new_chain;
		req.key.flat  = key;
		req.iv.flat   = iv;
		req.data.flat = data;
		in_valid      = 1'b1;
		while (!in_ready)
			@(negedge clk);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Waits for out_valid, stalls out_ready, then takes the result
	task automatic take_result(input string test_name, input int stall,
		output logic [127:0] result);
		while (!out_valid)
			@(negedge clk);
		result = rsp.data.flat;
		check_value({test_name, " in_ready"}, 1'b0, in_ready);
		repeat (stall)
		begin
			@(negedge clk);
			check_value({test_name, " hold"}, result, rsp.data.flat);
			check_value({test_name, " out_valid"}, 1'b1, out_valid);
			check_value({test_name, " in_ready"}, 1'b0, in_ready);
		end
		out_ready = 1'b1;
		@(negedge clk);
		out_ready = 1'b0;
		// Taken, core free again
		check_value({test_name, " taken"}, 1'b0, out_valid);
		check_value({test_name, " free"}, 1'b1, in_ready);
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================
	task automatic test_ecb();
		logic [127:0] result;
		send_request(AES_MODE_ECB, 1'b0, KEY_A, '0, PT_A);
		take_result("ecb_a", 0, result);
		check_value("ecb_a", CT_A, result);
		send_request(AES_MODE_ECB, 1'b0, KEY_B, '0, PT_B);
		take_result("ecb_b", 0, result);
		check_value("ecb_b", CT_B, result);
	endtask

	// Chain register cancels the XOR, cipher sees P both times
	task automatic test_cbc();
		logic [127:0] iv;
		logic [127:0] result;
		iv = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0;
		send_request(AES_MODE_CBC, 1'b1, KEY_B, iv, PT_B ^ iv);
		take_result("cbc_first", 0, result);
		check_value("cbc_first", CT_B, result);
		// Stale iv on the bus, ignored without new_chain
		send_request(AES_MODE_CBC, 1'b0, KEY_B, ~iv, PT_B ^ CT_B);
		take_result("cbc_second", 0, result);
		check_value("cbc_second", CT_B, result);
	endtask

	// Counter lands on P for the second block
	task automatic test_ctr();
		logic [127:0] iv;
		logic [127:0] data;
		logic [127:0] result;
		iv = PT_A;
		iv[`AES_CTR_WIDTH-1:0] = PT_A[`AES_CTR_WIDTH-1:0] - 1'b1;
		data = 128'hdeadbeef0123456789abcdeffedcba98;
		send_request(AES_MODE_CTR, 1'b1, KEY_A, iv, data);
		// Keystream of P-1, not among the vectors
		take_result("ctr_first", 0, result);
		send_request(AES_MODE_CTR, 1'b0, KEY_A, '0, data);
		take_result("ctr_second", 0, result);
		check_value("ctr_second", data ^ CT_A, result);
	endtask

	task automatic test_back_pressure();
		logic [127:0] result_a;
		logic [127:0] result_b;
		int           stall;
		stall = int'(random_bits(4)) + 1;
		send_request(AES_MODE_ECB, 1'b0, KEY_A, '0, PT_A);
		// Second request waits behind the stalled result
		fork
			send_request(AES_MODE_ECB, 1'b0, KEY_B, '0, PT_B);
			take_result("stall_a", stall, result_a);
		join
		check_value("stall_a", CT_A, result_a);
		stall = int'(random_bits(4)) + 1;
		take_result("stall_b", stall, result_b);
		check_value("stall_b", CT_B, result_b);
	endtask

	task automatic test_reset();
		logic [127:0] result;
		send_request(AES_MODE_ECB, 1'b0, KEY_B, '0, PT_B);
		// Somewhere in the early rounds
		repeat (20) @(negedge clk);
		apply_reset();
		check_value("reset out_valid", 1'b0, out_valid);
		check_value("reset in_ready", 1'b1, in_ready);
		// Aborted block never shows up
		repeat (`AES_LATENCY + 4)
		begin
			@(negedge clk);
			check_value("reset no result", 1'b0, out_valid);
		end
		send_request(AES_MODE_ECB, 1'b0, KEY_A, '0, PT_A);
		take_result("reset_ecb", 0, result);
		check_value("reset_ecb", CT_A, result);
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial
	begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		out_ready  = 1'b0;
		req        = '0;
		lfsr_state = 32'h81a9;
		apply_reset();
		test_ecb();
		test_cbc();
		test_ctr();
		test_back_pressure();
		test_reset();
		repeat (2) @(negedge clk);
		if (i_dut.i_assert.fail_count == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures during the run", i_dut.i_assert.fail_count);
			$display("STATUS: FAIL");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

// ==== files.f ====
+incdir+include
hdl/aes_pkg.sv
hdl/aes_sbox.sv
hdl/aes_key_schedule.sv
hdl/aes_round_datapath.sv
hdl/aes_control_unit.sv
hdl/aes_chain_unit.sv
hdl/aes_core_top.sv
dv/aes_assert.sv
dv/aes_tb.sv

// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/aes_pkg.sv
      - hdl/aes_sbox.sv
      - hdl/aes_key_schedule.sv
      - hdl/aes_round_datapath.sv
      - hdl/aes_control_unit.sv
      - hdl/aes_chain_unit.sv
      - hdl/aes_core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/aes_assert.sv
      - dv/aes_tb.sv
